/* rtl/wbuf_pkg.sv */
package wbuf_pkg;

    // bus and line sizes
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int OFFSET_W   = 3;
    localparam int LINE_WORDS = 1 << OFFSET_W;
    localparam int LINE_W     = LINE_WORDS * WORD_W;

    // buffer depth and occupancy count width
    localparam int DEPTH = 4;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // drain FSM encoding
    localparam int         ST_W    = 2;
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    // one cache line with word 0 in the low bits and sent first
    typedef union packed {
        logic [LINE_W-1:0]                  flat;
        logic [LINE_WORDS-1:0][WORD_W-1:0]  words;
    } line_u;

endpackage

/* rtl/write_buffer.sv */
`timescale 1ns/1ps

module write_buffer (
    input  logic                        clk,
    input  logic                        rstn,

    // insert port from the cache
    input  logic [wbuf_pkg::ADDR_W-1:0] in_addr,
    input  wbuf_pkg::line_u             in_data,
    input  logic                        in_valid,
    input  logic                        dma_busy,
    output logic                        in_ready,

    // same-cycle lookup
    input  logic [wbuf_pkg::ADDR_W-1:0] query_addr,
    output logic                        query_ok,
    output wbuf_pkg::line_u             query_data,

    // oldest entry towards the drain
    output logic [wbuf_pkg::ADDR_W-1:0] oldest_addr,
    output wbuf_pkg::line_u             oldest_line,
    output logic                        not_empty,
    input  logic                        pop,

    output logic [wbuf_pkg::CNT_W-1:0]  count
);

    import wbuf_pkg::*;

    // index 0 holds the newest entry
    logic [ADDR_W-1:0] entry_addr [DEPTH];
    logic [LINE_W-1:0] entry_line [DEPTH];

    logic              push;
    logic [DEPTH-1:0]  live;
    logic [DEPTH-1:0]  hit;

    assign in_ready  = (count < CNT_W'(DEPTH)) && !dma_busy;
    assign push      = in_valid && in_ready;
    assign not_empty = (count != '0);

    // push and pop on the same edge leave the count alone
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    // shift everything up one place on insert
    always_ff @(posedge clk) begin
        if (push) begin
            entry_addr[0] <= in_addr;
            entry_line[0] <= in_data.flat;
            for (int i = 1; i < DEPTH; i++) begin
                entry_addr[i] <= entry_addr[i-1];
                entry_line[i] <= entry_line[i-1];
            end
        end
    end

    // per-entry match limited to live entries
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            live[i] = CNT_W'(i) < count;
            hit[i]  = live[i] && (entry_addr[i] == query_addr);
        end
    end

    // walk from oldest to newest so the lowest index wins
    always_comb begin
        query_ok        = 1'b0;
        query_data.flat = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (hit[i]) begin
                query_ok        = 1'b1;
                query_data.flat = entry_line[i];
            end
        end
    end

    // oldest sits at count - 1
    always_comb begin
        oldest_addr      = '0;
        oldest_line.flat = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (count == CNT_W'(i + 1)) begin
                oldest_addr      = entry_addr[i];
                oldest_line.flat = entry_line[i];
            end
        end
    end

endmodule

/* rtl/drain_ctrl.sv */
`timescale 1ns/1ps

module drain_ctrl (
    input  logic                        clk,
    input  logic                        rstn,

    // oldest buffer entry
    input  logic [wbuf_pkg::ADDR_W-1:0] oldest_addr,
    input  wbuf_pkg::line_u             oldest_line,
    input  logic                        not_empty,
    output logic                        pop,

    // write address channel
    output logic [wbuf_pkg::ADDR_W-1:0] aw_addr,
    output logic                        aw_valid,
    input  logic                        aw_ready,

    // write data channel
    output logic [wbuf_pkg::WORD_W-1:0] w_data,
    output logic                        w_valid,
    output logic                        w_last,
    input  logic                        w_ready,

    // write response channel
    input  logic                        b_valid,
    output logic                        b_ready
);

    import wbuf_pkg::*;

    logic [ST_W-1:0]     state;
    logic [ST_W-1:0]     next_state;
    logic [OFFSET_W-1:0] beat;
    logic [ADDR_W-1:0]   addr_q;
    line_u               line_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic last_beat;

    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    assign b_fire    = b_valid && b_ready;
    assign last_beat = (beat == OFFSET_W'(LINE_WORDS - 1));

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (not_empty) begin
                    next_state = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (aw_fire) begin
                    next_state = ST_DATA;
                end
            end
            ST_DATA: begin
                if (w_fire && last_beat) begin
                    next_state = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_fire) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            state <= next_state;
            if (aw_fire) begin
                beat <= '0;
            end else if (w_fire) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // burst payload held until the burst is done
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && not_empty) begin
            addr_q <= oldest_addr;
        end
        if (aw_fire) begin
            line_q <= oldest_line;
        end
    end

    assign aw_addr  = addr_q;
    assign aw_valid = (state == ST_ADDR);

    assign w_data  = line_q.words[beat];
    assign w_valid = (state == ST_DATA);
    assign w_last  = (state == ST_DATA) && last_beat;

    assign b_ready = (state == ST_RESP);

    // entry leaves only once memory has acknowledged it
    assign pop = b_fire;

endmodule

/* rtl/wbuf_top.sv */
`timescale 1ns/1ps

module wbuf_top (
    input  logic                        clk,
    input  logic                        rstn,

    input  logic [wbuf_pkg::ADDR_W-1:0] in_addr,
    input  wbuf_pkg::line_u             in_data,
    input  logic                        in_valid,
    input  logic                        dma_busy,
    output logic                        in_ready,

    input  logic [wbuf_pkg::ADDR_W-1:0] query_addr,
    output logic                        query_ok,
    output wbuf_pkg::line_u             query_data,

    output logic [wbuf_pkg::ADDR_W-1:0] aw_addr,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output logic [wbuf_pkg::WORD_W-1:0] w_data,
    output logic                        w_valid,
    output logic                        w_last,
    input  logic                        w_ready,
    input  logic                        b_valid,
    output logic                        b_ready,

    output logic [wbuf_pkg::CNT_W-1:0]  pending
);

    import wbuf_pkg::*;

    // buffer to drain
    logic [ADDR_W-1:0] oldest_addr;
    line_u             oldest_line;
    logic              not_empty;
    logic              pop;

    write_buffer write_buffer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .in_addr     (in_addr),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .dma_busy    (dma_busy),
        .in_ready    (in_ready),
        .query_addr  (query_addr),
        .query_ok    (query_ok),
        .query_data  (query_data),
        .oldest_addr (oldest_addr),
        .oldest_line (oldest_line),
        .not_empty   (not_empty),
        .pop         (pop),
        .count       (pending)
    );

    drain_ctrl drain_ctrl_inst (
        .clk         (clk),
        .rstn        (rstn),
        .oldest_addr (oldest_addr),
        .oldest_line (oldest_line),
        .not_empty   (not_empty),
        .pop         (pop),
        .aw_addr     (aw_addr),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .w_data      (w_data),
        .w_valid     (w_valid),
        .w_last      (w_last),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .b_ready     (b_ready)
    );

endmodule

/* verification/axi_slave_model.sv */
`timescale 1ns/1ps

module axi_slave_model (
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic [31:0] aw_addr,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  logic [31:0] w_data,
    input  logic        w_valid,
    input  logic        w_last,
    output logic        w_ready,
    output logic        b_valid,
    input  logic        b_ready
);

    // received bursts in arrival order
    logic [31:0] addr_log [$];
    logic [31:0] data_log [$];
    logic        last_log [$];

    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] b_wait;
    logic       resp_pend;

    assign aw_ready = !stall && aw_valid && (aw_wait == 2'd0);
    assign w_ready  = !stall && w_valid && (w_wait == 2'd0);

    always @(posedge clk) begin
        if (!rstn) begin
            aw_wait   <= 2'd0;
            w_wait    <= 2'd0;
            b_wait    <= 2'd0;
            resp_pend <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                addr_log.push_back(aw_addr);
                aw_wait <= 2'($urandom_range(3, 0));
            end else if (aw_wait != 2'd0 && !stall) begin
                aw_wait <= aw_wait - 2'd1;
            end
            if (w_valid && w_ready) begin
                data_log.push_back(w_data);
                last_log.push_back(w_last);
                w_wait <= 2'($urandom_range(3, 0));
                if (w_last) begin
                    resp_pend <= 1'b1;
                end
            end else if (w_wait != 2'd0 && !stall) begin
                w_wait <= w_wait - 2'd1;
            end
            // response is held once raised
            if (b_valid && b_ready) begin
                b_valid   <= 1'b0;
                resp_pend <= 1'b0;
                b_wait    <= 2'($urandom_range(3, 0));
            end else if (resp_pend && !b_valid && !stall) begin
                if (b_wait == 2'd0) begin
                    b_valid <= 1'b1;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* verification/wbuf_tb.sv */
`timescale 1ns/1ps

module wbuf_tb;

    import wbuf_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + 200;

    logic              clk;
    logic              rstn;
    logic [ADDR_W-1:0] in_addr;
    line_u             in_data;
    logic              in_valid;
    logic              dma_busy;
    logic              in_ready;
    logic [ADDR_W-1:0] query_addr;
    logic              query_ok;
    line_u             query_data;
    logic [ADDR_W-1:0] aw_addr;
    logic              aw_valid;
    logic              aw_ready;
    logic [WORD_W-1:0] w_data;
    logic              w_valid;
    logic              w_last;
    logic              w_ready;
    logic              b_valid;
    logic              b_ready;
    logic [CNT_W-1:0]  pending;
    logic              stall;
    int                cycles;

    // entries 2 and 5 share an address
    logic [ADDR_W-1:0] tbl_addr [NUM_ENTRIES] = '{
        32'h0000_1000, 32'h0000_1020, 32'h0000_2040, 32'h0000_3000,
        32'h0000_1100, 32'h0000_2040, 32'h0000_4ee0, 32'h0000_5000
    };
    logic [WORD_W-1:0] tbl_seed [NUM_ENTRIES] = '{
        32'h1111_0000, 32'h2222_0100, 32'h3333_0200, 32'h4444_0300,
        32'h5555_0400, 32'h6666_0500, 32'h7777_0600, 32'h8888_0700
    };

    wbuf_top wbuf_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .dma_busy   (dma_busy),
        .in_ready   (in_ready),
        .query_addr (query_addr),
        .query_ok   (query_ok),
        .query_data (query_data),
        .aw_addr    (aw_addr),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w_data     (w_data),
        .w_valid    (w_valid),
        .w_last     (w_last),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .pending    (pending)
    );

    axi_slave_model axi_slave_model_inst (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .aw_addr  (aw_addr),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_data   (w_data),
        .w_valid  (w_valid),
        .w_last   (w_last),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Test failed");
            $fatal(1, "timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    // word i of a line is seed + i
    function automatic line_u make_line(input logic [WORD_W-1:0] seed);
        line_u l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l.words[i] = seed + WORD_W'(i);
        end
        return l;
    endfunction

    task automatic check(input string name, input logic [LINE_W-1:0] expected,
                         input logic [LINE_W-1:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic drive_entry(input int k);
        in_addr  = tbl_addr[k];
        in_data  = make_line(tbl_seed[k]);
        in_valid = 1'b1;
    endtask

    // leaves at the negedge after the accepting edge
    task automatic insert(input int k);
        @(negedge clk);
        drive_entry(k);
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic query_check(input string name, input logic [ADDR_W-1:0] addr,
                               input logic exp_ok, input line_u exp_line);
        @(negedge clk);
        query_addr = addr;
        #1;
        check({name, " ok"}, LINE_W'(exp_ok), LINE_W'(query_ok));
        check({name, " data"}, exp_line.flat, query_data.flat);
    endtask

    initial begin
        void'($urandom(32'h68ef_2a12));
        cycles     = 0;
        rstn       = 1'b0;
        in_addr    = '0;
        in_data    = '0;
        in_valid   = 1'b0;
        dma_busy   = 1'b0;
        query_addr = '0;
        stall      = 1'b1;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        // idle outputs straight out of reset
        #1;
        check("reset in_ready", 1, LINE_W'(in_ready));
        check("reset query_ok", '0, LINE_W'(query_ok));
        check("reset pending", '0, LINE_W'(pending));
        check("reset aw_valid", '0, LINE_W'(aw_valid));
        check("reset w_valid", '0, LINE_W'(w_valid));
        check("reset w_last", '0, LINE_W'(w_last));
        check("reset b_ready", '0, LINE_W'(b_ready));

        // dma blocks the first insert
        @(negedge clk);
        dma_busy = 1'b1;
        drive_entry(0);
        repeat (3) begin
            #1;
            check("dma in_ready", '0, LINE_W'(in_ready));
            check("dma pending", '0, LINE_W'(pending));
            @(negedge clk);
        end
        dma_busy = 1'b0;
        #1;
        check("dma release in_ready", 1, LINE_W'(in_ready));
        @(negedge clk);
        in_valid = 1'b0;
        #1;
        check("dma release pending", 1, LINE_W'(pending));
        query_check("hit 0", tbl_addr[0], 1'b1, make_line(tbl_seed[0]));

        for (int k = 1; k < DEPTH; k++) begin
            insert(k);
            query_check($sformatf("hit %0d", k), tbl_addr[k], 1'b1,
                        make_line(tbl_seed[k]));
        end

        // entry 4 must be refused while full
        @(negedge clk);
        drive_entry(4);
        #1;
        check("full in_ready", '0, LINE_W'(in_ready));
        check("full pending", DEPTH, LINE_W'(pending));
        @(negedge clk);
        in_valid = 1'b0;
        #1;
        check("full pending after", DEPTH, LINE_W'(pending));

        // drain entries 0 and 1 and hold 2 and 3 in place
        stall = 1'b0;
        while (pending != CNT_W'(2)) begin
            @(negedge clk);
        end
        stall = 1'b1;
        insert(4);
        insert(5);
        query_check("newest wins", tbl_addr[5], 1'b1, make_line(tbl_seed[5]));
        query_check("miss", 32'h0000_9f00, 1'b0, '0);

        stall = 1'b0;
        insert(6);
        insert(7);
        while (pending != '0 || axi_slave_model_inst.addr_log.size() < NUM_ENTRIES) begin
            @(negedge clk);
        end

        check("burst count", NUM_ENTRIES,
              LINE_W'(axi_slave_model_inst.addr_log.size()));
        check("beat count", NUM_ENTRIES * LINE_WORDS,
              LINE_W'(axi_slave_model_inst.data_log.size()));
        for (int b = 0; b < NUM_ENTRIES; b++) begin
            line_u exp_line;
            exp_line = make_line(tbl_seed[b]);
            check($sformatf("burst %0d addr", b), LINE_W'(tbl_addr[b]),
                  LINE_W'(axi_slave_model_inst.addr_log[b]));
            for (int i = 0; i < LINE_WORDS; i++) begin
                check($sformatf("burst %0d beat %0d", b, i), LINE_W'(exp_line.words[i]),
                      LINE_W'(axi_slave_model_inst.data_log[b * LINE_WORDS + i]));
                check($sformatf("burst %0d last %0d", b, i), LINE_W'(i == LINE_WORDS - 1),
                      LINE_W'(axi_slave_model_inst.last_log[b * LINE_WORDS + i]));
            end
        end

        check("drained pending", '0, LINE_W'(pending));
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            query_check($sformatf("drained miss %0d", k), tbl_addr[k], 1'b0, '0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* src.f */
rtl/wbuf_pkg.sv
rtl/write_buffer.sv
rtl/drain_ctrl.sv
rtl/wbuf_top.sv
verification/axi_slave_model.sv
verification/wbuf_tb.sv

/* Makefile */
TOP := wbuf_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module wbuf_top \
		rtl/wbuf_pkg.sv rtl/write_buffer.sv rtl/drain_ctrl.sv rtl/wbuf_top.sv

clean:
	rm -rf obj_dir
